// ==== design/cmd_fifo.sv ====
`timescale 1ns/1ps

module cmd_fifo import plot_cmd_pkg::*; #(
    parameter int fifo_depth  = fifo_depth_default,
    parameter int fifo_margin = fifo_margin_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_en,
    input  logic [cmd_word_w-1:0] wr_data,
    input  logic                  rd_en,     // only while not empty
    output logic [cmd_word_w-1:0] rd_data,   // head word, shown ahead
    output logic                  empty,
    output logic                  almost_full
);

    localparam int aw = $clog2(fifo_depth);       // pointer width
    localparam int cw = $clog2(fifo_depth + 1);   // fill count width

    logic [cmd_word_w-1:0] mem [fifo_depth];
    logic [aw-1:0]         wr_ptr;
    logic [aw-1:0]         rd_ptr;
    logic [cw-1:0]         count;
    logic                  do_wr;

    assign do_wr       = wr_en && (count != cw'(fifo_depth));   // drop when full
    assign empty       = (count == '0);
    assign almost_full = (count >= cw'(fifo_depth - fifo_margin));
    assign rd_data     = mem[rd_ptr];                           // show-ahead

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // idle or write and read together
            endcase
        end
    end

endmodule

// ==== design/coord_regs.sv ====
`timescale 1ns/1ps

module coord_regs import plot_geom_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       hold,        // pixel writer back-pressure
    input  logic       load_x,
    input  logic       load_y,
    input  logic [1:0] load_idx,
    input  coord_t     load_val,
    input  logic       set_max,     // copy point max_idx into the clip limits
    input  logic [1:0] max_idx,
    output coord_t     x_pts [4],
    output coord_t     y_pts [4],
    output coord_t     max_x,
    output coord_t     max_y
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                x_pts[i] <= '0;
                y_pts[i] <= '0;
            end
            max_x <= '0;           // everything clipped until limits are set
            max_y <= '0;
        end else if (!hold) begin
            if (load_x)
                x_pts[load_idx] <= load_val;
            if (load_y)
                y_pts[load_idx] <= load_val;
            if (set_max) begin
                max_x <= x_pts[max_idx];
                max_y <= y_pts[max_idx];
            end
        end
    end

endmodule

// ==== design/draw_cmd_emitter.sv ====
`timescale 1ns/1ps

module draw_cmd_emitter import plot_geom_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      draw_busy,
    input  logic      emit_pixel,
    input  logic      emit_cfg,
    input  draw_cmd_t cfg_word,
    input  color_t    pen_color,
    input  coord_t    pos_x,
    input  coord_t    pos_y,
    input  coord_t    max_x,
    input  coord_t    max_y,
    output draw_cmd_t draw_cmd,
    output logic      draw_cmd_rdy
);

    logic tx;          // registered transmit flag
    logic in_bounds;

    assign in_bounds = (pos_x >= 12'sd0) && (pos_x <= max_x) &&
                       (pos_y >= 12'sd0) && (pos_y <= max_y);

    assign draw_cmd_rdy = tx && !draw_busy;   // strobe only on a free cycle

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            tx <= 1'b0;
        else if (!draw_busy)
            tx <= emit_cfg || (emit_pixel && in_bounds);   // clipped pixels stay silent
    end

    always_ff @(posedge clk) begin
        if (!draw_busy) begin
            if (emit_cfg)
                draw_cmd <= cfg_word;
            else if (emit_pixel)
                draw_cmd <= '{func: fn_pixel_write, color: pen_color, y: pos_y, x: pos_x};
        end
    end

endmodule

// ==== design/geometry_xy_plotter.sv ====
`timescale 1ns/1ps

module geometry_xy_plotter import plot_cmd_pkg::*, plot_geom_pkg::*; #(
    parameter int fifo_depth  = fifo_depth_default,
    parameter int fifo_margin = fifo_margin_default
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fifo_cmd_ready,   // host write strobe
    input  logic [cmd_word_w-1:0] fifo_cmd_in,
    input  logic                  draw_busy,        // pixel writer stall
    output logic                  load_cmd,
    output logic                  draw_cmd_rdy,
    output logic [35:0]           draw_cmd,
    output logic                  fifo_cmd_busy
);

    logic [cmd_word_w-1:0] cmd_word;
    logic                  fifo_empty;
    logic                  cmd_take;
    logic                  load_x, load_y, set_max;
    logic [1:0]            load_idx, max_idx;
    coord_t                load_val;
    coord_t                x_pts [4];
    coord_t                y_pts [4];
    coord_t                max_x, max_y;
    coord_t                pos_x, pos_y;
    logic                  emit_pixel, emit_cfg;
    draw_cmd_t             cfg_word;
    color_t                pen_color;

    plot_ctrl_if ctrl ();

    cmd_fifo #(.fifo_depth(fifo_depth), .fifo_margin(fifo_margin)) u_fifo (
        .clk, .reset, .wr_en(fifo_cmd_ready), .wr_data(fifo_cmd_in), .rd_en(cmd_take),
        .rd_data(cmd_word), .empty(fifo_empty), .almost_full(fifo_cmd_busy));

    coord_regs u_coords (
        .clk, .reset, .hold(draw_busy), .load_x, .load_y, .load_idx, .load_val,
        .set_max, .max_idx, .x_pts, .y_pts, .max_x, .max_y);

    plot_sequencer u_seq (
        .clk, .reset, .hold(draw_busy), .cmd_valid(!fifo_empty), .cmd_word, .x_pts, .y_pts,
        .cmd_take, .load_cmd, .load_x, .load_y, .load_idx, .load_val, .set_max, .max_idx,
        .emit_pixel, .emit_cfg, .cfg_word, .pen_color, .ctrl(ctrl.seq));

    pixel_stepper u_step (
        .clk, .reset, .hold(draw_busy), .p0x(x_pts[0]), .p0y(y_pts[0]),
        .p1x(x_pts[1]), .p1y(y_pts[1]), .ctrl(ctrl.step), .pos_x, .pos_y);

    draw_cmd_emitter u_emit (
        .clk, .reset, .draw_busy, .emit_pixel, .emit_cfg, .cfg_word, .pen_color,
        .pos_x, .pos_y, .max_x, .max_y, .draw_cmd, .draw_cmd_rdy);

endmodule

// ==== design/pixel_stepper.sv ====
`timescale 1ns/1ps

module pixel_stepper import plot_geom_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   hold,
    input  coord_t p0x,
    input  coord_t p0y,
    input  coord_t p1x,
    input  coord_t p1y,
    plot_ctrl_if.step ctrl,
    output coord_t pos_x,
    output coord_t pos_y
);

    logic signed [12:0] dx_raw, dy_raw;   // point 1 minus point 0
    logic signed [12:0] dx_abs, dy_abs;
    logic signed [12:0] dx;               // |dx|
    logic signed [12:0] dy;               // -|dy|
    logic signed [14:0] err;              // Bresenham error term
    logic signed [15:0] e2;
    coord_t             sx, sy;           // step direction, +1 or -1
    coord_t             x_end;            // first x past the far edge
    logic               rect_mode;
    logic               fill_r;
    logic               x_step, y_step;
    logic               mid_row;

    assign dx_raw = 13'(p1x) - 13'(p0x);
    assign dy_raw = 13'(p1y) - 13'(p0y);
    assign dx_abs = dx_raw[12] ? -dx_raw : dx_raw;
    assign dy_abs = dy_raw[12] ? -dy_raw : dy_raw;

    assign e2      = {err, 1'b0};         // 2 * err
    assign x_step  = (e2 >= dy);
    assign y_step  = (e2 <= dx);
    assign x_end   = p1x + sx;
    assign mid_row = (pos_y != p0y) && (pos_y != p1y);

    assign ctrl.last_pixel = (pos_x == p1x) && (pos_y == p1y);
    assign ctrl.walk_done  = (pos_x == x_end);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pos_x     <= '0;
            pos_y     <= '0;
            sx        <= 12'sd1;
            sy        <= 12'sd1;
            dx        <= '0;
            dy        <= '0;
            err       <= '0;
            rect_mode <= 1'b0;
            fill_r    <= 1'b0;
        end else if (!hold) begin
            if (ctrl.start_line || ctrl.start_rect) begin
                pos_x     <= p0x;                            // start at point 0
                pos_y     <= p0y;
                sx        <= (p1x >= p0x) ? 12'sd1 : -12'sd1;
                sy        <= (p1y >= p0y) ? 12'sd1 : -12'sd1;
                dx        <= dx_abs;
                dy        <= -dy_abs;
                err       <= 15'(dx_abs) - 15'(dy_abs);      // dx + dy
                rect_mode <= ctrl.start_rect;
                fill_r    <= ctrl.fill;
            end else if (ctrl.advance && rect_mode) begin
                // **************************************************
                // rectangle, row major from x0 towards x1
                // **************************************************
                if (ctrl.walk_done) begin
                    pos_x <= p0x;                            // row wrap
                    pos_y <= pos_y + sy;
                end else if (fill_r || !mid_row || pos_x == p1x) begin
                    pos_x <= pos_x + sx;
                end else begin
                    pos_x <= p1x;                            // outline, skip to right edge
                end
            end else if (ctrl.advance) begin
                if (x_step)
                    pos_x <= pos_x + sx;
                if (y_step)
                    pos_y <= pos_y + sy;
                err <= err + (x_step ? 15'(dy) : 15'sd0) + (y_step ? 15'(dx) : 15'sd0);
            end
        end
    end

endmodule

// ==== design/plot_cmd_pkg.sv ====
package plot_cmd_pkg;

    localparam int cmd_word_w          = 16;   // host command word
    localparam int fifo_depth_default  = 512;  // words in the command FIFO
    localparam int fifo_margin_default = 32;   // free words left when busy rises

    // opcode classes, each value is the lowest opcode of its range
    typedef enum logic [7:0] {
        op_draw    = 8'h00,   // 0x00-0x1f, shape in 2:0, fill in 3
        op_none    = 8'h20,   // anything not decoded below
        op_set_max = 8'h5c,   // 0x5c-0x5f, point index 0x5f - op
        op_set_dst = 8'h7c,   // 0x7c-0x7f, point index op[1:0]
        op_load_x  = 8'h80,   // 0x80-0xbf, index in cmd 13:12
        op_load_y  = 8'hc0    // 0xc0-0xff
    } cmd_op_e;

    typedef enum logic [2:0] {
        shape_none = 3'd0,
        shape_line = 3'd1,
        shape_rect = 3'd2
    } shape_e;

    // map a raw opcode byte onto its class
    function automatic cmd_op_e decode_op(input logic [7:0] op);
        casez (op)
            8'b000?_????: decode_op = op_draw;
            8'b0101_11??: decode_op = op_set_max;
            8'b0111_11??: decode_op = op_set_dst;
            8'b10??_????: decode_op = op_load_x;
            8'b11??_????: decode_op = op_load_y;
            default:      decode_op = op_none;     // consumed, no effect
        endcase
    endfunction

endpackage

// ==== design/plot_ctrl_if.sv ====
`timescale 1ns/1ps

interface plot_ctrl_if;

    logic start_line;   // latch point 0 and line deltas
    logic start_rect;   // latch point 0 for a rectangle walk
    logic advance;      // take one step this cycle
    logic fill;         // filled rectangle, valid with start_rect
    logic last_pixel;   // position sits on point 1
    logic walk_done;    // x walked past the far edge of the row

    modport seq (
        output start_line, start_rect, advance, fill,
        input  last_pixel, walk_done
    );

    modport step (
        input  start_line, start_rect, advance, fill,
        output last_pixel, walk_done
    );

endinterface

// ==== design/plot_geom_pkg.sv ====
package plot_geom_pkg;

    typedef logic signed [11:0] coord_t;   // screen coordinate, may go negative
    typedef logic [7:0]         color_t;   // 8 bit palette index

    // function field of the pixel writer command
    typedef enum logic [3:0] {
        fn_nop          = 4'd0,    // nothing to do
        fn_pixel_write  = 4'd1,    // plot colour at y/x
        fn_set_dst_addr = 4'd14    // colour = bitplane mode, y:x = base address
    } draw_func_e;

    // **************************************************
    // 36 bit command towards the pixel writer
    // **************************************************
    typedef struct packed {
        draw_func_e func;    // 35:32
        color_t     color;   // 31:24
        coord_t     y;       // 23:12
        coord_t     x;       // 11:0
    } draw_cmd_t;

endpackage

// ==== design/plot_sequencer.sv ====
`timescale 1ns/1ps

module plot_sequencer import plot_cmd_pkg::*, plot_geom_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hold,
    input  logic                  cmd_valid,   // FIFO not empty
    input  logic [cmd_word_w-1:0] cmd_word,
    input  coord_t                x_pts [4],   // for the destination address
    input  coord_t                y_pts [4],
    output logic                  cmd_take,
    output logic                  load_cmd,
    output logic                  load_x,
    output logic                  load_y,
    output logic [1:0]            load_idx,
    output coord_t                load_val,
    output logic                  set_max,
    output logic [1:0]            max_idx,
    output logic                  emit_pixel,
    output logic                  emit_cfg,
    output draw_cmd_t             cfg_word,
    output color_t                pen_color,
    plot_ctrl_if.seq              ctrl
);

    typedef enum logic [1:0] {idle, line_setup, line_run, rect_run} state_e;

    state_e     state;
    logic [7:0] op;
    cmd_op_e    op_class;
    shape_e     shape;
    logic       draw_go;

    assign op       = cmd_word[15:8];
    assign op_class = decode_op(op);
    assign shape    = shape_e'(op[2:0]);

    // **************************************************
    // command decode, one word per idle cycle
    // **************************************************
    assign load_cmd = (state == idle);
    assign cmd_take = load_cmd && cmd_valid && !hold;
    assign draw_go  = cmd_take && (op_class == op_draw);

    assign load_x   = cmd_take && (op_class == op_load_x);
    assign load_y   = cmd_take && (op_class == op_load_y);
    assign load_idx = cmd_word[13:12];
    assign load_val = coord_t'(cmd_word[11:0]);
    assign set_max  = cmd_take && (op_class == op_set_max);
    assign max_idx  = 2'(8'h5f - op);                      // 0x5f selects point 0

    assign emit_cfg = cmd_take && (op_class == op_set_dst);
    assign cfg_word = '{func:  fn_set_dst_addr,
                        color: cmd_word[7:0],              // bitplane mode
                        y:     y_pts[op[1:0]],
                        x:     x_pts[op[1:0]]};

    assign ctrl.start_line = draw_go && (shape == shape_line);
    assign ctrl.start_rect = draw_go && (shape == shape_rect);
    assign ctrl.fill       = draw_go && op[3];
    assign ctrl.advance    = !hold && (state == line_run || state == rect_run);

    // no candidate on a rectangle row wrap
    assign emit_pixel = (state == line_run) || (state == rect_run && !ctrl.walk_done);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= idle;
            pen_color <= '0;
        end else if (!hold) begin
            case (state)
                idle: begin
                    if (draw_go)
                        pen_color <= cmd_word[7:0];
                    if (ctrl.start_line)
                        state <= line_setup;
                    else if (ctrl.start_rect)
                        state <= rect_run;             // other shapes are dropped
                end
                line_setup: state <= line_run;         // deltas settle
                line_run, rect_run: begin
                    if (ctrl.last_pixel)
                        state <= idle;                 // point 1 goes out this cycle
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== dv/plotter_asserts.sv ====
`timescale 1ns/1ps

module plotter_asserts (
    input logic        clk,
    input logic        reset,
    input logic        draw_busy,
    input logic        load_cmd,
    input logic        draw_cmd_rdy,
    input logic [35:0] draw_cmd
);

    int fail_count = 0;   // failed assertions, read by the testbench at the end

    // no strobe towards a stalled pixel writer
    rdy_while_busy: assert property (@(posedge clk) disable iff (reset)
        draw_busy |-> !draw_cmd_rdy)
        else begin
            $error("draw_cmd_rdy is high while draw_busy is high");
            fail_count++;
        end

    // sequencer comes out of reset ready for a command
    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> load_cmd)
        else begin
            $error("load_cmd is low in the first cycle after reset");
            fail_count++;
        end

    // output register frozen by a stall
    cmd_held_in_stall: assert property (@(posedge clk) disable iff (reset)
        $past(draw_busy) |-> $stable(draw_cmd))
        else begin
            $error("draw_cmd changed while draw_busy was high");
            fail_count++;
        end

endmodule

bind geometry_xy_plotter plotter_asserts asserts0 (
    .clk, .reset, .draw_busy, .load_cmd, .draw_cmd_rdy, .draw_cmd);

// ==== dv/plotter_testdata.txt ====
# test <name> <busy: none, rand or hold>, then cmd <16 bit words> and exp <36 bit draw_cmd>
# fill <word> <count> pushes the same command word count times
test set_dst none
cmd 87ff c7ff 5f00 a123 e045 7e3c
exp e3c045123
test lines none
cmd 8000 c000 9005 d002 0111
exp 111000000 111000001 111001002 111001003 111002004 111002005
cmd 800a c00a 9008 d00e 0122
exp 12200a00a 12200b009 12200c009 12200d008 12200e008
cmd 8014 c005 9010 d003 0133
exp 133005014 133004013 133004012 133003011 133003010
test rects none
cmd 8002 c001 9005 d003 0244
exp 144001002 144001003 144001004 144001005 144002002
exp 144002005 144003002 144003003 144003004 144003005
cmd 8003 c002 9001 d003 0a55
exp 155002003 155002002 155002001 155003003 155003002 155003001
test random_busy rand
cmd 800a c00a 9008 d00e 0122 8002 c001 9005 d003 0244
exp 12200a00a 12200b009 12200c009 12200d008 12200e008
exp 144001002 144001003 144001004 144001005 144002002
exp 144002005 144003002 144003003 144003004 144003005
test clip none
cmd a003 e002 5d00 8fff c001 9004 d003 0a66
exp 166001000 166001001 166001002 166001003 166002000 166002001 166002002 166002003
test fifo_fill hold
fill 2000 480

// ==== dv/tb_geometry_xy_plotter.sv ====
`timescale 1ns/1ps

module tb_geometry_xy_plotter;

    localparam int    fifo_depth  = 512;
    localparam int    fifo_margin = 32;
    localparam string data_path   = "dv/plotter_testdata.txt";

    logic        clk = 1'b0;
    logic        reset;
    logic        fifo_cmd_ready;
    logic [15:0] fifo_cmd_in;
    logic        draw_busy;
    logic        load_cmd;
    logic        draw_cmd_rdy;
    logic [35:0] draw_cmd;
    logic        fifo_cmd_busy;

    // **************************************************
    // test table, filled from the data file
    // **************************************************
    string       test_name [$];
    string       test_mode [$];   // none, rand or hold
    int          cmd_start [$];
    int          cmd_num   [$];
    int          exp_start [$];
    int          exp_num   [$];
    logic [15:0] cmds      [$];
    logic [35:0] exps      [$];
    logic [35:0] got       [$];   // draw commands seen on the output

    string busy_mode = "none";
    bit    hold_busy;             // stall held through the push phase
    bit    loaded;
    bit    file_ok;
    int    watchdog_cycles;
    int    errors;
    int    checks;

    geometry_xy_plotter #(.fifo_depth(fifo_depth), .fifo_margin(fifo_margin)) dut0 (
        .clk, .reset, .fifo_cmd_ready, .fifo_cmd_in, .draw_busy,
        .load_cmd, .draw_cmd_rdy, .draw_cmd, .fifo_cmd_busy);

    always #2 clk = ~clk;         // 4 ns period

    always @(posedge clk) begin
        if (!reset && draw_cmd_rdy)
            got.push_back(draw_cmd);   // one entry per strobe
    end

    task automatic load_tests();
        int          fd;
        int          kind;
        int          count;
        string       tok;
        string       rest;
        string       name;
        string       mode;
        logic [35:0] val;
        fd      = $fopen(data_path, "r");
        file_ok = (fd != 0);
        if (file_ok) begin
            kind = 0;
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));           // rest of a comment line
                end else if (tok == "test") begin
                    void'($fscanf(fd, "%s %s", name, mode));
                    test_name.push_back(name);
                    test_mode.push_back(mode);
                    cmd_start.push_back(cmds.size());
                    exp_start.push_back(exps.size());
                    cmd_num.push_back(0);
                    exp_num.push_back(0);
                end else if (tok == "cmd") begin
                    kind = 0;
                end else if (tok == "exp") begin
                    kind = 1;
                end else if (tok == "fill") begin
                    void'($fscanf(fd, "%h %d", val, count));
                    repeat (count)
                        cmds.push_back(val[15:0]);
                    cmd_num[cmd_num.size() - 1] += count;
                end else begin
                    void'($sscanf(tok, "%h", val));
                    if (kind == 0) begin
                        cmds.push_back(val[15:0]);
                        cmd_num[cmd_num.size() - 1]++;
                    end else begin
                        exps.push_back(val);
                        exp_num[exp_num.size() - 1]++;
                    end
                end
            end
            $fclose(fd);
            // every test also pushes one end marker
            watchdog_cycles = (cmds.size() + test_name.size() + exps.size()) * 8 + 2000;
            loaded = 1'b1;
        end
    endtask

    task automatic step_cycle();
        @(negedge clk);
        if (busy_mode == "rand")
            draw_busy = ($urandom % 3) == 0;
        else
            draw_busy = (busy_mode == "hold") && hold_busy;
    endtask

    task automatic run_test(input int t);
        int          n;
        int          errs_before;
        bit          found;
        logic [7:0]  marker;
        logic [15:0] sentinel;
        n           = cmd_num[t];
        errs_before = errors;
        marker      = 8'hf0 + 8'(t);          // colour tag no test uses
        sentinel    = {8'h7f, marker};        // set_dst of point 3 closes the test
        busy_mode   = test_mode[t];
        hold_busy   = 1'b1;
        got.delete();
        for (int k = 0; k <= n + 1; k++) begin
            step_cycle();
            if (busy_mode == "hold") begin   // k words stored, nothing read
                checks++;
                assert (fifo_cmd_busy == (k >= fifo_depth - fifo_margin)) else begin
                    $display("Error %s: fifo_cmd_busy at %0d words expected %b, actual %b",
                             test_name[t], k, k >= fifo_depth - fifo_margin, fifo_cmd_busy);
                    errors++;
                end
            end
            fifo_cmd_ready = (k <= n);
            fifo_cmd_in    = (k < n) ? cmds[cmd_start[t] + k] : sentinel;
        end
        hold_busy = 1'b0;
        found     = 1'b0;
        while (!found) begin
            step_cycle();
            found = (got.size() > 0) && (got[got.size() - 1][35:24] == {4'd14, marker});
        end
        void'(got.pop_back());
        checks++;
        assert (load_cmd && !fifo_cmd_busy) else begin
            $display("Error %s: load_cmd/fifo_cmd_busy expected 1/0, actual %b/%b",
                     test_name[t], load_cmd, fifo_cmd_busy);
            errors++;
        end
        checks++;
        assert (got.size() == exp_num[t]) else begin
            $display("test %s expected %0d draw commands but %0d arrived",
                     test_name[t], exp_num[t], got.size());
            errors++;
        end
        for (int k = 0; k < got.size() && k < exp_num[t]; k++) begin
            checks++;
            assert (got[k] == exps[exp_start[t] + k]) else begin
                $display("Error %s: draw command %0d expected %h, actual %h",
                         test_name[t], k, exps[exp_start[t] + k], got[k]);
                errors++;
            end
        end
        $display("test %s done, %0d draw commands, %0d errors",
                 test_name[t], got.size(), errors - errs_before);
    endtask

    // **************************************************
    // main sequence and watchdog
    // **************************************************
    initial begin
        reset          = 1'b1;
        fifo_cmd_ready = 1'b0;
        fifo_cmd_in    = '0;
        draw_busy      = 1'b0;
        errors         = 0;
        checks         = 0;
        void'($urandom(63058));              // single seed for the run
        load_tests();
        if (!file_ok) begin
            $display("cannot open the test data file %s", data_path);
            $display("Result: FAILED");
            $finish;
        end else begin
            repeat (16) @(negedge clk);
            reset = 1'b0;
            for (int t = 0; t < test_name.size(); t++)
                run_test(t);
            $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                     test_name.size(), checks, errors, dut0.asserts0.fail_count);
            if (errors == 0 && dut0.asserts0.fail_count == 0)
                $display("Result: PASSED");
            else
                $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        wait (loaded);
        repeat (watchdog_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped answering",
                 watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
design/plot_cmd_pkg.sv
design/plot_geom_pkg.sv
design/plot_ctrl_if.sv
design/cmd_fifo.sv
design/coord_regs.sv
design/pixel_stepper.sv
design/plot_sequencer.sv
design/draw_cmd_emitter.sv
design/geometry_xy_plotter.sv
dv/plotter_asserts.sv
dv/tb_geometry_xy_plotter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the geometry plotter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_geometry_xy_plotter -f filelist.f \
    --Mdir obj_dir -o sim_plotter > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_plotter +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" sim.log; then
    exit 0
fi
exit 1
